//--- hdl/dram_sched_pkg.sv
package dram_sched_pkg;

	// channel geometry
	localparam int NUM_BANKS   = 4;
	localparam int BANK_W      = 2; // log2(NUM_BANKS)
	localparam int ROW_W       = 8;
	localparam int COL_W       = 6;
	localparam int QUEUE_DEPTH = 8; // power of two so fifo pointers wrap by themselves

	// per-bank timings, clk cycles
	localparam int T_RCD = 3;  // act -> rd/wr
	localparam int T_RP  = 3;  // pre -> act
	localparam int T_RAS = 8;  // act -> pre
	localparam int T_RC  = 11; // act -> act, same bank

	// channel timings, any bank
	localparam int T_CCD = 2; // rd/wr -> rd/wr
	localparam int T_RRD = 2; // act -> act

	// refresh
	localparam int T_REFI = 200; // ref interval
	localparam int T_RFC  = 10;  // channel blocked after ref

	localparam int TIMER_W = 8; // all down-counters, must hold T_REFI

	// dram command encoding
	typedef enum logic [2:0] {
		NOP = 3'd0,
		ACT = 3'd1,
		PRE = 3'd2,
		RD  = 3'd3,
		WR  = 3'd4,
		REF = 3'd5
	} dram_cmd_t;

	// one queued request, 17 bits
	typedef struct packed {
		logic              write; // 1 = write, 0 = read
		logic [BANK_W-1:0] bank;
		logic [ROW_W-1:0]  row;
		logic [COL_W-1:0]  col;
	} mem_req_t;

endpackage

//--- hdl/req_if.sv
`timescale 1ns/1ps

// head of the request queue, fifo -> fsm
interface req_if;

	logic                             valid; // fifo not empty
	logic                             write;
	logic [dram_sched_pkg::BANK_W-1:0] bank;
	logic [dram_sched_pkg::ROW_W-1:0]  row;
	logic [dram_sched_pkg::COL_W-1:0]  col;
	logic                             pop;   // head served, one cycle

	// fifo side
	modport source (
		output valid, write, bank, row, col,
		input  pop
	);

	// scheduler side
	modport sink (
		input  valid, write, bank, row, col,
		output pop
	);

endinterface

//--- hdl/cmd_if.sv
`timescale 1ns/1ps

// issued dram command, seen by the timers and the bank table
interface cmd_if;

	logic                             valid; // one-cycle pulse per command
	dram_sched_pkg::dram_cmd_t         cmd;
	logic [dram_sched_pkg::BANK_W-1:0] bank;
	logic [dram_sched_pkg::ROW_W-1:0]  row;
	logic [dram_sched_pkg::COL_W-1:0]  col;

	// fsm drives
	modport source (
		output valid, cmd, bank, row, col
	);

	// everyone else listens
	modport monitor (
		input valid, cmd, bank, row, col
	);

endinterface

//--- hdl/req_fifo.sv
`timescale 1ns/1ps

module req_fifo (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     push,       // new request strobe
	input  dram_sched_pkg::mem_req_t push_req,
	output logic                     queue_full, // no free entry
	req_if.source                    head        // oldest request
);

	dram_sched_pkg::mem_req_t mem [dram_sched_pkg::QUEUE_DEPTH]; // payload only

	logic [$clog2(dram_sched_pkg::QUEUE_DEPTH)-1:0] wr_ptr;
	logic [$clog2(dram_sched_pkg::QUEUE_DEPTH)-1:0] rd_ptr;
	logic [$clog2(dram_sched_pkg::QUEUE_DEPTH):0]   count; // one extra bit for full

	logic wr_en;
	logic rd_en;

	assign queue_full = (count == dram_sched_pkg::QUEUE_DEPTH);
	assign wr_en      = push && !queue_full; // a push into a full queue is dropped
	assign rd_en      = head.pop && head.valid;

	// head is read straight out of the array
	assign head.valid = (count != '0);
	assign head.write = mem[rd_ptr].write;
	assign head.bank  = mem[rd_ptr].bank;
	assign head.row   = mem[rd_ptr].row;
	assign head.col   = mem[rd_ptr].col;

	always_ff @(posedge clk) begin
		if (wr_en) mem[wr_ptr] <= push_req;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (rd_en) rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	// the scheduler only retires a request it could see
	a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
		head.pop |-> head.valid);

	// source has to hold back while full
	a_push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> !queue_full);

endmodule

//--- hdl/bank_table.sv
`timescale 1ns/1ps

module bank_table (
	input  logic clk,
	input  logic rst_n,
	cmd_if.monitor issued, // registered command pulse
	output logic [dram_sched_pkg::NUM_BANKS-1:0]                           open_mask,
	output logic [dram_sched_pkg::NUM_BANKS-1:0][dram_sched_pkg::ROW_W-1:0] open_row
);

	// open flags, updated the cycle after the command shows up
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			open_mask <= '0; // all banks closed out of reset
		end else if (issued.valid) begin
			case (issued.cmd)
				dram_sched_pkg::ACT: open_mask[issued.bank] <= 1'b1;
				dram_sched_pkg::PRE: open_mask[issued.bank] <= 1'b0;
				dram_sched_pkg::REF: open_mask <= '0; // refresh leaves everything closed
				default: ;                             // rd/wr keep the row open
			endcase
		end
	end

	// row address per bank, only meaningful while the open flag is set
	always_ff @(posedge clk) begin
		if (issued.valid && issued.cmd == dram_sched_pkg::ACT)
			open_row[issued.bank] <= issued.row;
	end

	// fsm must precharge before it activates another row
	a_act_on_closed: assert property (@(posedge clk) disable iff (!rst_n)
		(issued.valid && issued.cmd == dram_sched_pkg::ACT) |-> !open_mask[issued.bank]);

endmodule

//--- hdl/timing_counters.sv
`timescale 1ns/1ps

module timing_counters (
	input  logic clk,
	input  logic rst_n,
	cmd_if.monitor issued, // registered command pulse
	output logic [dram_sched_pkg::NUM_BANKS-1:0] act_ok,  // bank may take act
	output logic [dram_sched_pkg::NUM_BANKS-1:0] pre_ok,  // bank may take pre
	output logic [dram_sched_pkg::NUM_BANKS-1:0] rdwr_ok, // bank may take rd/wr
	output logic ref_due,  // refresh interval elapsed
	output logic rfc_busy  // refresh still running
);

	logic [dram_sched_pkg::NUM_BANKS-1:0][dram_sched_pkg::TIMER_W-1:0] rcd_cnt;
	logic [dram_sched_pkg::NUM_BANKS-1:0][dram_sched_pkg::TIMER_W-1:0] ras_cnt;
	logic [dram_sched_pkg::NUM_BANKS-1:0][dram_sched_pkg::TIMER_W-1:0] rp_cnt;
	logic [dram_sched_pkg::NUM_BANKS-1:0][dram_sched_pkg::TIMER_W-1:0] rc_cnt;
	logic [dram_sched_pkg::TIMER_W-1:0] ccd_cnt;
	logic [dram_sched_pkg::TIMER_W-1:0] rrd_cnt;
	logic [dram_sched_pkg::TIMER_W-1:0] refi_cnt;
	logic [dram_sched_pkg::TIMER_W-1:0] rfc_cnt;

	// the load lands one cycle after the pulse and the fsm decides one cycle
	// after a zero, so two cycles of the gap are already covered
	function automatic logic [dram_sched_pkg::TIMER_W-1:0] gap_load(input int t);
		logic [dram_sched_pkg::TIMER_W-1:0] v;
		v = t[dram_sched_pkg::TIMER_W-1:0];
		return v - 2'd2;
	endfunction

	function automatic logic [dram_sched_pkg::TIMER_W-1:0] sat_dec(
		input logic [dram_sched_pkg::TIMER_W-1:0] x
	);
		return (x == '0) ? x : x - 1'b1; // stick at zero
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rcd_cnt  <= '0;
			ras_cnt  <= '0;
			rp_cnt   <= '0;
			rc_cnt   <= '0;
			ccd_cnt  <= '0;
			rrd_cnt  <= '0;
			rfc_cnt  <= '0;
			refi_cnt <= dram_sched_pkg::T_REFI[dram_sched_pkg::TIMER_W-1:0];
		end else begin
			for (int b = 0; b < dram_sched_pkg::NUM_BANKS; b++) begin
				rcd_cnt[b] <= sat_dec(rcd_cnt[b]);
				ras_cnt[b] <= sat_dec(ras_cnt[b]);
				rp_cnt[b]  <= sat_dec(rp_cnt[b]);
				rc_cnt[b]  <= sat_dec(rc_cnt[b]);
			end
			ccd_cnt  <= sat_dec(ccd_cnt);
			rrd_cnt  <= sat_dec(rrd_cnt);
			rfc_cnt  <= sat_dec(rfc_cnt);
			refi_cnt <= sat_dec(refi_cnt);
			// loads below override the decrement
			if (issued.valid) begin
				case (issued.cmd)
					dram_sched_pkg::ACT: begin
						rcd_cnt[issued.bank] <= gap_load(dram_sched_pkg::T_RCD);
						ras_cnt[issued.bank] <= gap_load(dram_sched_pkg::T_RAS);
						rc_cnt[issued.bank]  <= gap_load(dram_sched_pkg::T_RC);
						rrd_cnt              <= gap_load(dram_sched_pkg::T_RRD); // any bank
					end
					dram_sched_pkg::PRE: rp_cnt[issued.bank] <= gap_load(dram_sched_pkg::T_RP);
					dram_sched_pkg::RD,
					dram_sched_pkg::WR:  ccd_cnt <= gap_load(dram_sched_pkg::T_CCD);
					dram_sched_pkg::REF: begin
						rfc_cnt  <= gap_load(dram_sched_pkg::T_RFC);
						// restart interval
						refi_cnt <= dram_sched_pkg::T_REFI[dram_sched_pkg::TIMER_W-1:0];
					end
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		for (int b = 0; b < dram_sched_pkg::NUM_BANKS; b++) begin
			act_ok[b]  = (rp_cnt[b] == '0) && (rc_cnt[b] == '0) && (rrd_cnt == '0);
			pre_ok[b]  = (ras_cnt[b] == '0);
			rdwr_ok[b] = (rcd_cnt[b] == '0) && (ccd_cnt == '0);
		end
	end

	assign ref_due  = (refi_cnt == '0);
	assign rfc_busy = (rfc_cnt != '0);

	// flags only rise between loads, so the pulse cycle still shows what the fsm saw
	a_cmd_allowed: assert property (@(posedge clk) disable iff (!rst_n)
		issued.valid |-> !rfc_busy &&
		(issued.cmd != dram_sched_pkg::ACT || act_ok[issued.bank]) &&
		(issued.cmd != dram_sched_pkg::PRE || pre_ok[issued.bank]) &&
		((issued.cmd != dram_sched_pkg::RD && issued.cmd != dram_sched_pkg::WR) ||
			rdwr_ok[issued.bank]) &&
		(issued.cmd != dram_sched_pkg::REF || (&act_ok)));

endmodule

//--- hdl/cmd_fsm.sv
`timescale 1ns/1ps

module cmd_fsm (
	input  logic clk,
	input  logic rst_n,
	req_if.sink    head,  // oldest request
	cmd_if.source  issue, // registered command out
	input  logic [dram_sched_pkg::NUM_BANKS-1:0]                           open_mask,
	input  logic [dram_sched_pkg::NUM_BANKS-1:0][dram_sched_pkg::ROW_W-1:0] open_row,
	input  logic [dram_sched_pkg::NUM_BANKS-1:0]                           act_ok,
	input  logic [dram_sched_pkg::NUM_BANKS-1:0]                           pre_ok,
	input  logic [dram_sched_pkg::NUM_BANKS-1:0]                           rdwr_ok,
	input  logic ref_due,
	input  logic rfc_busy
);

	typedef enum logic [2:0] {
		IDLE,      // serve the head request
		SETTLE,    // let timers and bank table catch up
		REF_CLOSE, // precharge open banks before refresh
		REF_ISSUE, // all closed, wait for tRP then REF
		REF_WAIT   // tRFC running
	} state_t;

	state_t state;
	state_t state_nxt;

	logic                              go;         // issue a command this edge
	logic                              go_pop;     // it finishes the head
	dram_sched_pkg::dram_cmd_t         go_cmd;
	logic [dram_sched_pkg::BANK_W-1:0] go_bank;
	logic [dram_sched_pkg::BANK_W-1:0] close_bank; // lowest open bank
	logic                              row_hit;

	assign row_hit = open_mask[head.bank] && (open_row[head.bank] == head.row);

	always_comb begin
		close_bank = '0;
		for (int b = dram_sched_pkg::NUM_BANKS - 1; b >= 0; b--) begin
			if (open_mask[b]) close_bank = b[dram_sched_pkg::BANK_W-1:0]; // lowest wins
		end
	end

	always_comb begin
		state_nxt = state;
		go        = 1'b0;
		go_pop    = 1'b0;
		go_cmd    = dram_sched_pkg::NOP;
		go_bank   = head.bank;
		case (state)
			IDLE: begin
				if (ref_due) begin
					state_nxt = REF_CLOSE; // stop starting requests
				end else if (head.valid) begin
					if (row_hit) begin
						go     = rdwr_ok[head.bank];
						go_pop = rdwr_ok[head.bank];
						go_cmd = head.write ? dram_sched_pkg::WR : dram_sched_pkg::RD;
					end else if (!open_mask[head.bank]) begin
						go     = act_ok[head.bank]; // closed bank, open the row
						go_cmd = dram_sched_pkg::ACT;
					end else begin
						go     = pre_ok[head.bank]; // wrong row open
						go_cmd = dram_sched_pkg::PRE;
					end
					if (go) state_nxt = SETTLE;
				end
			end
			SETTLE: state_nxt = ref_due ? REF_CLOSE : IDLE;
			REF_CLOSE: begin
				if (open_mask == '0) begin
					state_nxt = REF_ISSUE;
				end else if (pre_ok[close_bank]) begin
					go        = 1'b1;
					go_cmd    = dram_sched_pkg::PRE;
					go_bank   = close_bank;
					state_nxt = SETTLE; // comes back here while ref_due holds
				end
			end
			REF_ISSUE: begin
				if (&act_ok) begin // tRP done everywhere
					go        = 1'b1;
					go_cmd    = dram_sched_pkg::REF;
					state_nxt = REF_WAIT;
				end
			end
			// the ref pulse itself masks the cycle before rfc_busy rises
			REF_WAIT: if (!issue.valid && !rfc_busy) state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= IDLE;
			issue.valid <= 1'b0;
			issue.cmd   <= dram_sched_pkg::NOP;
			head.pop    <= 1'b0;
		end else begin
			state       <= state_nxt;
			issue.valid <= go;     // single-cycle pulse
			issue.cmd   <= go_cmd; // NOP when idle
			head.pop    <= go_pop;
		end
	end

	// address fields, held between commands
	always_ff @(posedge clk) begin
		if (go) begin
			issue.bank <= go_bank;
			issue.row  <= head.row;
			issue.col  <= head.col;
		end
	end

endmodule

//--- hdl/dram_sched.sv
`timescale 1ns/1ps

module dram_sched (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              req_valid,
	input  logic                              req_write,
	input  logic [dram_sched_pkg::BANK_W-1:0] req_bank,
	input  logic [dram_sched_pkg::ROW_W-1:0]  req_row,
	input  logic [dram_sched_pkg::COL_W-1:0]  req_col,
	output logic                              queue_full,
	output logic                              cmd_valid,
	output dram_sched_pkg::dram_cmd_t         cmd,
	output logic [dram_sched_pkg::BANK_W-1:0] cmd_bank,
	output logic [dram_sched_pkg::ROW_W-1:0]  cmd_row,
	output logic [dram_sched_pkg::COL_W-1:0]  cmd_col
);

	dram_sched_pkg::mem_req_t push_req;

	logic [dram_sched_pkg::NUM_BANKS-1:0]                           open_mask;
	logic [dram_sched_pkg::NUM_BANKS-1:0][dram_sched_pkg::ROW_W-1:0] open_row;
	logic [dram_sched_pkg::NUM_BANKS-1:0]                           act_ok;
	logic [dram_sched_pkg::NUM_BANKS-1:0]                           pre_ok;
	logic [dram_sched_pkg::NUM_BANKS-1:0]                           rdwr_ok;
	logic                                                           ref_due;
	logic                                                           rfc_busy;

	req_if head_bus ();  // fifo head -> fsm
	cmd_if issue_bus (); // fsm -> timers, bank table, pins

	assign push_req = '{write: req_write, bank: req_bank, row: req_row, col: req_col};

	req_fifo u_req_fifo (
		.clk(clk), .rst_n(rst_n), .push(req_valid), .push_req(push_req),
		.queue_full(queue_full), .head(head_bus.source)
	);

	bank_table u_bank_table (
		.clk(clk), .rst_n(rst_n), .issued(issue_bus.monitor),
		.open_mask(open_mask), .open_row(open_row)
	);

	timing_counters u_timing_counters (
		.clk(clk), .rst_n(rst_n), .issued(issue_bus.monitor), .act_ok(act_ok),
		.pre_ok(pre_ok), .rdwr_ok(rdwr_ok), .ref_due(ref_due), .rfc_busy(rfc_busy)
	);

	cmd_fsm u_cmd_fsm (
		.clk(clk), .rst_n(rst_n), .head(head_bus.sink), .issue(issue_bus.source),
		.open_mask(open_mask), .open_row(open_row), .act_ok(act_ok), .pre_ok(pre_ok),
		.rdwr_ok(rdwr_ok), .ref_due(ref_due), .rfc_busy(rfc_busy)
	);

	// command pins come straight off the fsm registers
	assign cmd_valid = issue_bus.valid;
	assign cmd       = issue_bus.cmd;
	assign cmd_bank  = issue_bus.bank;
	assign cmd_row   = issue_bus.row;
	assign cmd_col   = issue_bus.col;

endmodule

//--- verification/dram_sched_tb.sv
`timescale 1ns/1ps

module dram_sched_tb;

	localparam int CLK_PERIOD      = 40;
	localparam int NUM_REQ         = 24;
	localparam int BURST_LEN       = 12; // back-to-back row misses, no idle gaps
	localparam int WATCHDOG_CYCLES = NUM_REQ * 40 + 4 * dram_sched_pkg::T_REFI;

	// columns: write, bank, row, col
	localparam dram_sched_pkg::mem_req_t REQS [NUM_REQ] = '{
		'{1'b0, 2'd0, 8'h10, 6'h01}, '{1'b1, 2'd0, 8'h20, 6'h02}, // bank 0 misses fill the queue
		'{1'b0, 2'd0, 8'h10, 6'h03}, '{1'b1, 2'd0, 8'h20, 6'h04},
		'{1'b0, 2'd0, 8'h30, 6'h05}, '{1'b0, 2'd0, 8'h10, 6'h06},
		'{1'b1, 2'd0, 8'h20, 6'h07}, '{1'b0, 2'd0, 8'h30, 6'h08},
		'{1'b1, 2'd0, 8'h10, 6'h09}, '{1'b0, 2'd0, 8'h20, 6'h0a},
		'{1'b0, 2'd0, 8'h30, 6'h0b}, '{1'b1, 2'd0, 8'h10, 6'h0c},
		'{1'b0, 2'd0, 8'h10, 6'h0d}, '{1'b0, 2'd1, 8'h44, 6'h10}, // hit, then closed bank
		'{1'b1, 2'd1, 8'h44, 6'h11}, '{1'b0, 2'd2, 8'h55, 6'h12},
		'{1'b1, 2'd3, 8'h66, 6'h13}, '{1'b0, 2'd2, 8'h55, 6'h14},
		'{1'b1, 2'd1, 8'h45, 6'h15}, '{1'b0, 2'd3, 8'h66, 6'h16},
		'{1'b0, 2'd3, 8'h67, 6'h17}, '{1'b1, 2'd2, 8'h55, 6'h18},
		'{1'b0, 2'd0, 8'h11, 6'h19}, '{1'b1, 2'd1, 8'h45, 6'h1a}
	};

	logic                              clk;
	logic                              rst_n;
	logic                              req_valid;
	logic                              req_write;
	logic [dram_sched_pkg::BANK_W-1:0] req_bank;
	logic [dram_sched_pkg::ROW_W-1:0]  req_row;
	logic [dram_sched_pkg::COL_W-1:0]  req_col;
	logic                              queue_full;
	logic                              cmd_valid;
	dram_sched_pkg::dram_cmd_t         cmd;
	logic [dram_sched_pkg::BANK_W-1:0] cmd_bank;
	logic [dram_sched_pkg::ROW_W-1:0]  cmd_row;
	logic [dram_sched_pkg::COL_W-1:0]  cmd_col;

	integer seed;
	int     cyc;        // rising edges since time zero
	int     accepted;   // requests taken into the queue
	int     served;     // rd/wr seen so far, index into REQS
	int     full_waits; // requests that found the queue full
	int     ref_count;

	// reference open-row model and last-issue cycles
	logic                             open_m [dram_sched_pkg::NUM_BANKS];
	logic [dram_sched_pkg::ROW_W-1:0] orow_m [dram_sched_pkg::NUM_BANKS];
	int                               last_act [dram_sched_pkg::NUM_BANKS];
	int                               last_pre [dram_sched_pkg::NUM_BANKS];
	int                               last_act_any;
	int                               last_rdwr;
	int                               last_ref;

	dram_sched u_dut (
		.clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_write(req_write),
		.req_bank(req_bank), .req_row(req_row), .req_col(req_col), .queue_full(queue_full),
		.cmd_valid(cmd_valid), .cmd(cmd), .cmd_bank(cmd_bank), .cmd_row(cmd_row),
		.cmd_col(cmd_col)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_cmd(
		input dram_sched_pkg::dram_cmd_t got,
		input dram_sched_pkg::dram_cmd_t exp
	);
		if (got !== exp) abort_run($sformatf("Error: cmd expected %h got %h", exp, got));
	endtask

	task automatic check_addr(
		input logic [dram_sched_pkg::BANK_W-1:0] bank,
		input logic [dram_sched_pkg::ROW_W-1:0]  row,
		input logic [dram_sched_pkg::COL_W-1:0]  col,
		input dram_sched_pkg::mem_req_t          exp
	);
		if (bank !== exp.bank)
			abort_run($sformatf("Error: cmd_bank expected %h got %h", exp.bank, bank));
		if (row !== exp.row)
			abort_run($sformatf("Error: cmd_row expected %h got %h", exp.row, row));
		if (col !== exp.col)
			abort_run($sformatf("Error: cmd_col expected %h got %h", exp.col, col));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) abort_run($sformatf("Error: %s expected %h got %h", name, exp, got));
	endtask

	// cycles between the earlier command and the one seen now
	task automatic check_gap(input string name, input int since, input int min_gap);
		if (cyc - since < min_gap)
			abort_run($sformatf("%s gap of %0d cycles is below %0d", name, cyc - since, min_gap));
	endtask

	// wait for room, then hold the strobe for exactly one edge
	task automatic send_req(input dram_sched_pkg::mem_req_t r);
		@(negedge clk);
		if (queue_full) full_waits++;
		while (queue_full) @(negedge clk);
		@(posedge clk);
		req_valid <= 1'b1;
		req_write <= r.write;
		req_bank  <= r.bank;
		req_row   <= r.row;
		req_col   <= r.col;
		@(posedge clk);
		req_valid <= 1'b0;
		accepted++; // room was there, and nothing else pushes meanwhile
	endtask

	// command outputs are registers, stable at the falling edge
	always @(negedge clk) begin : monitor
		int b;
		if (rst_n) begin
			// entries in use are requests taken in minus rd/wr already retired
			check_flag("queue_full", queue_full,
				(accepted - served) == dram_sched_pkg::QUEUE_DEPTH);
		end
		if (rst_n && cmd_valid) begin
			b = cmd_bank;
			check_gap("command after REF (tRFC)", last_ref, dram_sched_pkg::T_RFC);
			case (cmd)
				dram_sched_pkg::ACT: begin
					if (open_m[b])
						abort_run($sformatf("ACT to bank %0d which is already open", b));
					check_gap("PRE to ACT (tRP)", last_pre[b], dram_sched_pkg::T_RP);
					check_gap("ACT to ACT same bank (tRC)", last_act[b], dram_sched_pkg::T_RC);
					check_gap("ACT to ACT (tRRD)", last_act_any, dram_sched_pkg::T_RRD);
					open_m[b]    = 1'b1;
					orow_m[b]    = cmd_row;
					last_act[b]  = cyc;
					last_act_any = cyc;
				end
				dram_sched_pkg::PRE: begin
					if (!open_m[b]) abort_run($sformatf("PRE to bank %0d which is closed", b));
					check_gap("ACT to PRE (tRAS)", last_act[b], dram_sched_pkg::T_RAS);
					open_m[b]   = 1'b0;
					last_pre[b] = cyc;
				end
				dram_sched_pkg::RD, dram_sched_pkg::WR: begin
					if (served >= NUM_REQ) abort_run("more RD or WR commands than requests sent");
					if (!open_m[b] || orow_m[b] !== cmd_row)
						abort_run($sformatf("RD or WR to a row that is not open in bank %0d", b));
					check_gap("ACT to RD/WR (tRCD)", last_act[b], dram_sched_pkg::T_RCD);
					check_gap("RD/WR to RD/WR (tCCD)", last_rdwr, dram_sched_pkg::T_CCD);
					check_cmd(cmd,
						REQS[served].write ? dram_sched_pkg::WR : dram_sched_pkg::RD);
					check_addr(cmd_bank, cmd_row, cmd_col, REQS[served]);
					last_rdwr = cyc;
					served++;
				end
				dram_sched_pkg::REF: begin
					for (int i = 0; i < dram_sched_pkg::NUM_BANKS; i++)
						if (open_m[i])
							abort_run($sformatf("REF while bank %0d is still open", i));
					check_gap("REF to REF (tREFI)", last_ref, dram_sched_pkg::T_REFI);
					last_ref = cyc; // ref leaves every bank closed, model already agrees
					ref_count++;
				end
				default: abort_run($sformatf("cmd_valid high with unknown command %h", cmd));
			endcase
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("timeout while waiting for all requests and two refreshes");
	end

	initial begin
		int gap;
		clk          = 1'b0;
		rst_n        = 1'b0;
		req_valid    = 1'b0;
		req_write    = 1'b0;
		req_bank     = '0;
		req_row      = '0;
		req_col      = '0;
		seed         = 32'h4f08;
		cyc          = 0;
		accepted     = 0;
		served       = 0;
		full_waits   = 0;
		ref_count    = 0;
		last_act_any = -1000; // far enough back to pass every gap
		last_rdwr    = -1000;
		last_ref     = -1000;
		for (int i = 0; i < dram_sched_pkg::NUM_BANKS; i++) begin
			open_m[i]   = 1'b0;
			orow_m[i]   = '0;
			last_act[i] = -1000;
			last_pre[i] = -1000;
		end
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_flag("queue_full", queue_full, 1'b0);
		check_flag("cmd_valid", cmd_valid, 1'b0);
		for (int i = 0; i < NUM_REQ; i++) begin
			gap = (i < BURST_LEN) ? 0 : $unsigned($random(seed)) % 4; // burst stays dense
			repeat (gap) @(posedge clk);
			send_req(REQS[i]);
		end
		wait (served == NUM_REQ && ref_count >= 2);
		@(negedge clk);
		if (full_waits > 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			abort_run("queue_full never rose during the row-miss burst");
		end
	end

endmodule

//--- dram_sched.f
hdl/dram_sched_pkg.sv
hdl/req_if.sv
hdl/cmd_if.sv
hdl/req_fifo.sv
hdl/bank_table.sv
hdl/timing_counters.sv
hdl/cmd_fsm.sv
hdl/dram_sched.sv
verification/dram_sched_tb.sv

//--- Bender.yml
package:
  name: dram_sched

sources:
  - hdl/dram_sched_pkg.sv
  - hdl/req_if.sv
  - hdl/cmd_if.sv
  - hdl/req_fifo.sv
  - hdl/bank_table.sv
  - hdl/timing_counters.sv
  - hdl/cmd_fsm.sv
  - hdl/dram_sched.sv
  - target: test
    files:
      - verification/dram_sched_tb.sv
